//--- build.f
+incdir+hdl
+incdir+verification
hdl/mem_layout_pkg.sv
hdl/dac_types_pkg.sv
hdl/dac_intf.sv
hdl/pwl_gen.sv
hdl/dac_output_stage.sv
hdl/dac_subsystem.sv
verification/dac_subsystem_tb.sv

//--- hdl/dac_intf.sv
`timescale 1ns/1ps
`include "dac_params.svh"

module dac_intf (
	input logic ps_clk,
	input logic reset,
	input logic [`DAC_MEM_SIZE-1:0] fresh_bits,
	input logic [`DAC_MEM_SIZE-1:0][`DAC_DATA_WIDTH-1:0] read_resps,
	input logic halt,
	input dac_types_pkg::scale_t scale_factor_in,
	input dac_types_pkg::burst_t dac_bs_in,
	input logic burst_done,
	input logic pwl_empty,
	output logic dac_intf_rdy,
	output dac_types_pkg::scale_t scale_factor_out,
	output dac_types_pkg::burst_t dac_bs_out,
	output dac_types_pkg::mode_t mode,
	output logic run_start,
	output dac_types_pkg::batch_t seed_batch,
	output dac_types_pkg::batch_t trig_batch
);
	localparam int LANE_BITS = $clog2(`DAC_BATCH_SIZE);

	logic busy;
	logic hit;
	logic consume;
	logic start_ok;
	logic [`DAC_DATA_WIDTH-1:0] word;
	logic [1:0] trig_wait;
	mem_layout_pkg::id_t hit_id;
	mem_layout_pkg::id_t seed_lane;
	dac_types_pkg::mode_t start_mode;
	dac_types_pkg::sample_t ramp_base;

	// ----------------------------------------------------------------------
	// Mailbox scan, lowest index wins
	// ----------------------------------------------------------------------
	always_comb begin
		hit = 1'b0;
		hit_id = '0;
		for (int i = `DAC_MEM_SIZE-1; i >= 0; i--) begin
			if (fresh_bits[i]) begin
				hit = 1'b1;
				hit_id = mem_layout_pkg::id_t'(i);
			end
		end
	end

	assign dac_intf_rdy = ~busy; // Low for the cycle after a word is taken.
	assign consume = hit & dac_intf_rdy;
	assign word = read_resps[hit_id];
	assign seed_lane = hit_id - mem_layout_pkg::SEED_BASE_ID;

	// Map a start word to the run it requests.
	always_comb begin
		start_mode = dac_types_pkg::IDLE;
		case (hit_id)
			mem_layout_pkg::SEED_VALID_ID: begin
				if (word != '0) start_mode = dac_types_pkg::SEED;
			end
			mem_layout_pkg::TRIG_WAVE_ID: start_mode = dac_types_pkg::TRIG;
			mem_layout_pkg::RUN_PWL_ID: begin
				if (!pwl_empty) start_mode = dac_types_pkg::PWL; // Empty table is ignored.
			end
			default: start_mode = dac_types_pkg::IDLE;
		endcase
	end

	assign start_ok = consume && (mode == dac_types_pkg::IDLE) &&
		(start_mode != dac_types_pkg::IDLE);

	// ----------------------------------------------------------------------
	// Mode FSM and configuration latch
	// ----------------------------------------------------------------------
	always_ff @(posedge ps_clk) begin
		if (reset) begin
			busy <= 1'b0;
			mode <= dac_types_pkg::IDLE;
			run_start <= 1'b0;
			scale_factor_out <= '0;
			dac_bs_out <= '0;
		end else begin
			busy <= consume;
			run_start <= start_ok & ~halt;
			if (halt || burst_done) begin
				mode <= dac_types_pkg::IDLE;
			end else if (start_ok) begin
				mode <= start_mode;
			end
			if (mode == dac_types_pkg::IDLE) begin // Runs keep their settings.
				scale_factor_out <= scale_factor_in;
				dac_bs_out <= dac_bs_in;
			end
		end
	end

	// Seed lanes are payload only.
	always_ff @(posedge ps_clk) begin
		if (consume && (seed_lane < `DAC_BATCH_SIZE)) begin
			seed_batch[seed_lane[LANE_BITS-1:0]] <= word;
		end
	end

	// ----------------------------------------------------------------------
	// Ramp counter
	// ----------------------------------------------------------------------
	// The wait covers the two cycles before the output stage emits batch 0.
	always_ff @(posedge ps_clk) begin
		if (reset) begin
			ramp_base <= '0;
			trig_wait <= '0;
		end else if (start_ok) begin
			ramp_base <= '0;
			trig_wait <= 2'd2;
		end else if (trig_wait != '0) begin
			trig_wait <= trig_wait - 2'd1;
		end else if (mode == dac_types_pkg::TRIG) begin
			ramp_base <= ramp_base + `DAC_DATA_WIDTH'(`DAC_BATCH_SIZE); // Wraps at 16 bits.
		end
	end

	always_comb begin
		for (int i = 0; i < `DAC_BATCH_SIZE; i++) begin
			trig_batch[i] = ramp_base + `DAC_DATA_WIDTH'(i);
		end
	end

endmodule

//--- hdl/dac_output_stage.sv
`timescale 1ns/1ps
`include "dac_params.svh"

module dac_output_stage (
	input logic ps_clk,
	input logic reset,
	input dac_types_pkg::mode_t mode,
	input logic run_start,
	input logic halt,
	input dac_types_pkg::scale_t scale_factor,
	input dac_types_pkg::burst_t burst_size,
	input dac_types_pkg::batch_t seed_batch,
	input dac_types_pkg::batch_t trig_batch,
	input dac_types_pkg::batch_t pwl_batch,
	output logic valid_dac_batch,
	output dac_types_pkg::batch_t dac_batch,
	output dac_types_pkg::burst_t halt_counter,
	output logic advance,
	output logic burst_done
);
	logic start_d1;
	logic active; // A batch is emitted on every edge while set.
	dac_types_pkg::burst_t count;
	dac_types_pkg::batch_t sel_batch;
	dac_types_pkg::batch_t shifted;

	// ----------------------------------------------------------------------
	// Source select and scaling
	// ----------------------------------------------------------------------
	always_comb begin
		case (mode)
			dac_types_pkg::SEED: sel_batch = seed_batch;
			dac_types_pkg::TRIG: sel_batch = trig_batch;
			dac_types_pkg::PWL: sel_batch = pwl_batch;
			default: sel_batch = '0;
		endcase
		for (int i = 0; i < `DAC_BATCH_SIZE; i++) begin
			shifted[i] = $signed(sel_batch[i]) >>> scale_factor; // Sign kept.
		end
	end

	assign advance = active;
	assign burst_done = active && (burst_size != '0) &&
		(dac_types_pkg::burst_t'(count + 1'b1) == burst_size);
	assign halt_counter = count;

	// ----------------------------------------------------------------------
	// Run control and burst count
	// ----------------------------------------------------------------------
	always_ff @(posedge ps_clk) begin
		if (reset) begin
			start_d1 <= 1'b0;
			active <= 1'b0;
			valid_dac_batch <= 1'b0;
			count <= '0;
		end else begin
			start_d1 <= run_start & ~halt;
			if (halt || burst_done) begin
				active <= 1'b0;
			end else if (start_d1) begin
				active <= 1'b1;
			end
			valid_dac_batch <= active & ~halt;
			if (run_start) begin
				count <= '0;
			end else if (active && !halt) begin
				count <= count + 1'b1; // Holds after the burst ends.
			end
		end
	end

	always_ff @(posedge ps_clk) begin
		if (active) dac_batch <= shifted;
	end

endmodule

//--- hdl/dac_params.svh
`ifndef DAC_PARAMS_SVH
`define DAC_PARAMS_SVH

// ----------------------------------------------------------------------
// Sample and batch geometry
// ----------------------------------------------------------------------
`define DAC_DATA_WIDTH 16 // Bits per DAC sample.
`define DAC_BATCH_SIZE 4 // Samples per batch.

// ----------------------------------------------------------------------
// Processor mailbox and DMA
// ----------------------------------------------------------------------
`define DAC_MEM_SIZE 16 // Mailbox response words.
`define DAC_DMA_WIDTH 64 // One PWL segment per DMA word.

// ----------------------------------------------------------------------
// Run control
// ----------------------------------------------------------------------
`define DAC_MAX_BURST 15 // Largest nonzero burst size.
`define DAC_PWL_DEPTH 16 // Segment slots in the PWL table.

`endif

//--- hdl/dac_subsystem.sv
`timescale 1ns/1ps
`include "dac_params.svh"

module dac_subsystem (
	input logic ps_clk,
	input logic reset,
	input logic [`DAC_MEM_SIZE-1:0] fresh_bits,
	input logic [`DAC_MEM_SIZE-1:0][`DAC_DATA_WIDTH-1:0] read_resps,
	input logic halt,
	input dac_types_pkg::scale_t scale_factor_in,
	input dac_types_pkg::burst_t dac_bs_in,
	input logic dma_valid,
	input logic dma_last,
	input logic [`DAC_DMA_WIDTH-1:0] dma_data,
	output logic dma_ready,
	output logic dac_intf_rdy,
	output logic pwl_rdy,
	output dac_types_pkg::scale_t scale_factor_out,
	output dac_types_pkg::burst_t dac_bs_out,
	output logic valid_dac_batch,
	output dac_types_pkg::batch_t dac_batch,
	output dac_types_pkg::burst_t halt_counter
);
	dac_types_pkg::mode_t mode;
	dac_types_pkg::batch_t seed_batch;
	dac_types_pkg::batch_t trig_batch;
	dac_types_pkg::batch_t pwl_batch;
	logic run_start;
	logic advance;
	logic burst_done;
	logic pwl_empty;

	dac_intf u_dac_intf (
		.ps_clk(ps_clk), .reset(reset),
		.fresh_bits(fresh_bits), .read_resps(read_resps), .halt(halt),
		.scale_factor_in(scale_factor_in), .dac_bs_in(dac_bs_in),
		.burst_done(burst_done), .pwl_empty(pwl_empty), .dac_intf_rdy(dac_intf_rdy),
		.scale_factor_out(scale_factor_out), .dac_bs_out(dac_bs_out),
		.mode(mode), .run_start(run_start),
		.seed_batch(seed_batch), .trig_batch(trig_batch)
	);

	pwl_gen u_pwl_gen (
		.ps_clk(ps_clk), .reset(reset),
		.mode(mode), .run_start(run_start), .advance(advance),
		.dma_valid(dma_valid), .dma_last(dma_last), .dma_data(dma_data),
		.dma_ready(dma_ready), .pwl_rdy(pwl_rdy), .pwl_empty(pwl_empty),
		.pwl_batch(pwl_batch)
	);

	dac_output_stage u_dac_output_stage (
		.ps_clk(ps_clk), .reset(reset),
		.mode(mode), .run_start(run_start), .halt(halt),
		.scale_factor(scale_factor_out), .burst_size(dac_bs_out), // Latched copies.
		.seed_batch(seed_batch), .trig_batch(trig_batch), .pwl_batch(pwl_batch),
		.valid_dac_batch(valid_dac_batch), .dac_batch(dac_batch),
		.halt_counter(halt_counter), .advance(advance), .burst_done(burst_done)
	);

endmodule

//--- hdl/dac_types_pkg.sv
`include "dac_params.svh"

package dac_types_pkg;

	typedef logic signed [`DAC_DATA_WIDTH-1:0] sample_t;

	// Lane 0 sits in the low bits.
	typedef logic [`DAC_BATCH_SIZE-1:0][`DAC_DATA_WIDTH-1:0] batch_t;

	typedef enum logic [1:0] {
		IDLE,
		SEED,
		TRIG,
		PWL
	} mode_t;

	typedef logic [$clog2(`DAC_DATA_WIDTH)-1:0] scale_t; // Right shift.
	typedef logic [$clog2(`DAC_MAX_BURST):0] burst_t; // Zero runs until halt.

	// One DMA word, upper bits unused.
	typedef struct packed {
		logic [`DAC_DMA_WIDTH-49:0] unused;
		logic [15:0] len_batches;
		sample_t slope;
		sample_t start;
	} pwl_seg_t;

endpackage

//--- hdl/mem_layout_pkg.sv
`include "dac_params.svh"

package mem_layout_pkg;

	// Index of one mailbox response word.
	typedef logic [$clog2(`DAC_MEM_SIZE)-1:0] id_t;

	// ----------------------------------------------------------------------
	// Seed batch words
	// ----------------------------------------------------------------------
	localparam id_t SEED_BASE_ID = 0; // Lane 0, next lanes follow.
	localparam id_t SEED_VALID_ID = 4; // Nonzero value arms the seed run.

	// ----------------------------------------------------------------------
	// Run triggers
	// ----------------------------------------------------------------------
	localparam id_t TRIG_WAVE_ID = 5; // Ramp source.
	localparam id_t RUN_PWL_ID = 6; // PWL table source.

endpackage

//--- hdl/pwl_gen.sv
`timescale 1ns/1ps
`include "dac_params.svh"

module pwl_gen (
	input logic ps_clk,
	input logic reset,
	input dac_types_pkg::mode_t mode,
	input logic run_start,
	input logic advance,
	input logic dma_valid,
	input logic dma_last,
	input logic [`DAC_DMA_WIDTH-1:0] dma_data,
	output logic dma_ready,
	output logic pwl_rdy,
	output logic pwl_empty,
	output dac_types_pkg::batch_t pwl_batch
);
	localparam int SEG_BITS = $clog2(`DAC_PWL_DEPTH);
	localparam int CNT_BITS = SEG_BITS + 1;

	dac_types_pkg::pwl_seg_t seg_mem [`DAC_PWL_DEPTH];

	logic [CNT_BITS-1:0] seg_count;
	logic [SEG_BITS-1:0] wr_slot;
	logic pkt_done; // Next transfer starts a fresh table.
	logic idle_q;
	logic dma_xfer;

	logic prime;
	logic shift;
	logic [SEG_BITS-1:0] seg_ptr;
	logic [15:0] b_ptr;
	logic [SEG_BITS-1:0] src_seg;
	logic [15:0] src_b;
	logic src_last_b;
	logic src_last_s;
	dac_types_pkg::pwl_seg_t src_entry;

	dac_types_pkg::sample_t s1_start;
	dac_types_pkg::sample_t s1_slope;
	logic [15:0] s1_base;

	// ----------------------------------------------------------------------
	// Table load from the DMA stream
	// ----------------------------------------------------------------------
	assign dma_ready = idle_q && (mode == dac_types_pkg::IDLE) &&
		(pkt_done || (seg_count < CNT_BITS'(`DAC_PWL_DEPTH)));
	assign dma_xfer = dma_valid & dma_ready;
	assign wr_slot = pkt_done ? '0 : seg_count[SEG_BITS-1:0];
	assign pwl_rdy = pkt_done;
	assign pwl_empty = (seg_count == '0);

	always_ff @(posedge ps_clk) begin
		if (reset) begin
			idle_q <= 1'b0;
			pkt_done <= 1'b1;
			seg_count <= '0;
		end else begin
			idle_q <= (mode == dac_types_pkg::IDLE);
			if (dma_xfer) begin
				pkt_done <= dma_last;
				seg_count <= pkt_done ? CNT_BITS'(1) : seg_count + 1'b1;
			end
		end
	end

	always_ff @(posedge ps_clk) begin
		if (dma_xfer) seg_mem[wr_slot] <= dac_types_pkg::pwl_seg_t'(dma_data);
	end

	// ----------------------------------------------------------------------
	// Segment walk
	// ----------------------------------------------------------------------
	assign shift = (mode == dac_types_pkg::PWL) && (run_start || prime || advance);
	assign src_seg = run_start ? '0 : seg_ptr; // A run always begins at segment 0.
	assign src_b = run_start ? '0 : b_ptr;
	assign src_entry = seg_mem[src_seg];
	assign src_last_b = ({1'b0, src_b} + 17'd1) >= {1'b0, src_entry.len_batches};
	assign src_last_s = ({1'b0, src_seg} + 1'b1) >= seg_count;

	always_ff @(posedge ps_clk) begin
		if (reset) begin
			prime <= 1'b0;
			seg_ptr <= '0;
			b_ptr <= '0;
		end else begin
			prime <= run_start && (mode == dac_types_pkg::PWL); // Second preload step.
			if (shift) begin
				if (src_last_b) begin
					b_ptr <= '0;
					seg_ptr <= src_last_s ? '0 : src_seg + 1'b1;
				end else begin
					b_ptr <= src_b + 16'd1;
					seg_ptr <= src_seg;
				end
			end
		end
	end

	// ----------------------------------------------------------------------
	// Two-stage interpolator
	// ----------------------------------------------------------------------
	always_ff @(posedge ps_clk) begin
		if (shift) begin
			s1_start <= src_entry.start;
			s1_slope <= src_entry.slope;
			s1_base <= src_b * 16'(`DAC_BATCH_SIZE);
			for (int i = 0; i < `DAC_BATCH_SIZE; i++) begin
				pwl_batch[i] <= s1_start + s1_slope * (s1_base + 16'(i)); // Low 16 bits.
			end
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Compiles the DAC subsystem testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

TOP=dac_subsystem_tb
OBJ_DIR=obj_dir

verilator --binary --timing -j 0 \
	--timescale 1ns/1ps \
	--top-module "$TOP" \
	--Mdir "$OBJ_DIR" \
	-f build.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "Verilator compile failed with status $status"
	exit "$status"
fi

"./$OBJ_DIR/V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit "$status"
fi

echo "Simulation finished cleanly"
exit 0

//--- verification/dac_tb_tasks.svh
`ifndef DAC_TB_TASKS_SVH
`define DAC_TB_TASKS_SVH

// ----------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------
task automatic check_batch(input string name, input dac_types_pkg::batch_t got,
		input dac_types_pkg::batch_t exp);
	if (got !== exp) begin
		fail_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
	end
endtask

task automatic check_count(input string name, input dac_types_pkg::burst_t got,
		input dac_types_pkg::burst_t exp);
	if (got !== exp) begin
		fail_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
	end
endtask

task automatic check_scale(input string name, input dac_types_pkg::scale_t got,
		input dac_types_pkg::scale_t exp);
	if (got !== exp) begin
		fail_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
	end
endtask

task automatic check_bs(input string name, input dac_types_pkg::burst_t got,
		input dac_types_pkg::burst_t exp);
	if (got !== exp) begin
		fail_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
	end
endtask

// ----------------------------------------------------------------------
// Mailbox and DMA drivers, called on a falling edge
// ----------------------------------------------------------------------
task automatic write_mailbox(input mem_layout_pkg::id_t id, input logic [15:0] value);
	int waited;
	read_resps[id] = value;
	fresh_bits[id] = 1'b1;
	waited = 0;
	while (dac_intf_rdy !== 1'b1) begin
		@(negedge ps_clk);
		waited++;
		if (waited > WAIT_LIMIT) fail_run("Timed out waiting for the mailbox to take a word.");
	end
	@(negedge ps_clk); // Word taken on the edge just passed.
	fresh_bits[id] = 1'b0;
endtask

task automatic send_dma_word(input logic [`DAC_DMA_WIDTH-1:0] data, input logic last);
	int waited;
	dma_valid = 1'b1;
	dma_data = data;
	dma_last = last;
	waited = 0;
	while (dma_ready !== 1'b1) begin
		@(negedge ps_clk);
		waited++;
		if (waited > WAIT_LIMIT) fail_run("Timed out waiting for dma_ready.");
	end
	@(negedge ps_clk);
	dma_valid = 1'b0;
	dma_last = 1'b0;
endtask

`endif

//--- verification/dac_subsystem_tb.sv
`timescale 1ns/1ps
`include "dac_params.svh"

module dac_subsystem_tb;
	localparam int WAIT_LIMIT = 64; // Cycles allowed for any single wait.

	logic ps_clk;
	logic reset;
	logic [`DAC_MEM_SIZE-1:0] fresh_bits;
	logic [`DAC_MEM_SIZE-1:0][`DAC_DATA_WIDTH-1:0] read_resps;
	logic halt;
	dac_types_pkg::scale_t scale_factor_in;
	dac_types_pkg::burst_t dac_bs_in;
	logic dma_valid;
	logic dma_last;
	logic [`DAC_DMA_WIDTH-1:0] dma_data;
	logic dma_ready;
	logic dac_intf_rdy;
	logic pwl_rdy;
	dac_types_pkg::scale_t scale_factor_out;
	dac_types_pkg::burst_t dac_bs_out;
	logic valid_dac_batch;
	dac_types_pkg::batch_t dac_batch;
	dac_types_pkg::burst_t halt_counter;

	integer seed;
	dac_types_pkg::batch_t exp_q [$]; // Expected batches in output order.
	dac_types_pkg::sample_t seg_start [`DAC_PWL_DEPTH];
	dac_types_pkg::sample_t seg_slope [`DAC_PWL_DEPTH];
	int seg_len [`DAC_PWL_DEPTH];
	int n_segs;

	dac_subsystem u_dut (
		.ps_clk(ps_clk), .reset(reset), .fresh_bits(fresh_bits), .read_resps(read_resps),
		.halt(halt), .scale_factor_in(scale_factor_in), .dac_bs_in(dac_bs_in),
		.dma_valid(dma_valid), .dma_last(dma_last), .dma_data(dma_data),
		.dma_ready(dma_ready), .dac_intf_rdy(dac_intf_rdy), .pwl_rdy(pwl_rdy),
		.scale_factor_out(scale_factor_out), .dac_bs_out(dac_bs_out),
		.valid_dac_batch(valid_dac_batch), .dac_batch(dac_batch),
		.halt_counter(halt_counter)
	);

	initial begin
		ps_clk = 1'b0;
		forever #4 ps_clk = ~ps_clk;
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "Stopped at the first error.");
	endtask

	`include "dac_tb_tasks.svh"

	// ----------------------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------------------
	function automatic int next_random();
		return $random(seed);
	endfunction

	function automatic int rand_range(input int lo, input int hi);
		int span;
		span = hi - lo + 1;
		return lo + int'($unsigned(next_random()) % $unsigned(span));
	endfunction

	function automatic dac_types_pkg::batch_t shift_batch(input dac_types_pkg::batch_t raw,
			input dac_types_pkg::scale_t sh);
		dac_types_pkg::batch_t shifted;
		dac_types_pkg::sample_t lane;
		for (int i = 0; i < `DAC_BATCH_SIZE; i++) begin
			lane = raw[i];
			shifted[i] = lane >>> sh; // Sign is kept.
		end
		return shifted;
	endfunction

	task automatic add_ramp(input int count, input dac_types_pkg::scale_t sh);
		dac_types_pkg::batch_t raw;
		for (int k = 0; k < count; k++) begin
			for (int i = 0; i < `DAC_BATCH_SIZE; i++) begin
				raw[i] = 16'(k * `DAC_BATCH_SIZE + i); // Wraps at 16 bits.
			end
			exp_q.push_back(shift_batch(raw, sh));
		end
	endtask

	task automatic add_pwl_period(input dac_types_pkg::scale_t sh);
		dac_types_pkg::batch_t raw;
		for (int s = 0; s < n_segs; s++) begin
			for (int b = 0; b < seg_len[s]; b++) begin
				for (int i = 0; i < `DAC_BATCH_SIZE; i++) begin
					raw[i] = 16'(int'(seg_start[s]) +
						int'(seg_slope[s]) * (b * `DAC_BATCH_SIZE + i));
				end
				exp_q.push_back(shift_batch(raw, sh));
			end
		end
	endtask

	task automatic make_segments();
		n_segs = rand_range(3, 6);
		for (int s = 0; s < n_segs; s++) begin
			seg_start[s] = 16'(next_random());
			seg_slope[s] = 16'(next_random());
			seg_len[s] = rand_range(1, 3);
		end
	endtask

	// Upper DMA bits carry noise that the table must ignore.
	task automatic load_table();
		logic [`DAC_DMA_WIDTH-1:0] word;
		for (int s = 0; s < n_segs; s++) begin
			word = {16'(next_random()), 16'(seg_len[s]), seg_slope[s], seg_start[s]};
			send_dma_word(word, s == n_segs - 1);
			if (pwl_rdy !== (s == n_segs - 1)) fail_run("pwl_rdy does not follow the packet.");
			repeat (rand_range(0, 3)) @(negedge ps_clk);
		end
	endtask

	// ----------------------------------------------------------------------
	// Run control
	// ----------------------------------------------------------------------
	task automatic apply_config(input dac_types_pkg::scale_t sh, input dac_types_pkg::burst_t bs);
		scale_factor_in = sh;
		dac_bs_in = bs;
		@(negedge ps_clk); // Copied on the next edge while idle.
		check_scale("scale_factor_out", scale_factor_out, sh);
		check_bs("dac_bs_out", dac_bs_out, bs);
	endtask

	task automatic await_first_batch();
		int waited;
		waited = 0;
		while (valid_dac_batch !== 1'b1) begin
			@(negedge ps_clk);
			waited++;
			if (waited > WAIT_LIMIT) fail_run("Timed out waiting for valid_dac_batch.");
		end
	endtask

	task automatic follow_run();
		dac_types_pkg::batch_t expected;
		await_first_batch();
		while (exp_q.size() > 0) begin
			if (valid_dac_batch !== 1'b1) fail_run("valid_dac_batch dropped in the middle of a run.");
			if (dma_ready !== 1'b0) fail_run("dma_ready is high during a run.");
			expected = exp_q.pop_front();
			check_batch("dac_batch", dac_batch, expected);
			@(negedge ps_clk);
		end
	endtask

	// Counts valid batches until the stream stops by itself.
	task automatic count_burst(output int seen);
		dac_types_pkg::batch_t expected;
		seen = 0;
		await_first_batch();
		while (valid_dac_batch === 1'b1) begin
			if (exp_q.size() == 0) fail_run("The burst ran past its burst size.");
			expected = exp_q.pop_front();
			check_batch("dac_batch", dac_batch, expected);
			seen++;
			@(negedge ps_clk);
		end
	endtask

	task automatic halt_run();
		halt = 1'b1;
		@(negedge ps_clk);
		halt = 1'b0;
		if (valid_dac_batch !== 1'b0) fail_run("valid_dac_batch is still high after halt.");
		exp_q.delete();
	endtask

	task automatic expect_quiet(input int cycles);
		repeat (cycles) begin
			@(negedge ps_clk);
			if (valid_dac_batch !== 1'b0) fail_run("A batch appeared while the DAC was idle.");
			if (dac_intf_rdy !== 1'b1) fail_run("dac_intf_rdy is low while the DAC is idle.");
		end
	endtask

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------
	initial begin
		dac_types_pkg::batch_t raw;
		dac_types_pkg::scale_t sh;
		dac_types_pkg::burst_t bs;
		int seen;
		seed = 32'h9ebe6f21;
		reset = 1'b1;
		fresh_bits = '0;
		read_resps = '0;
		halt = 1'b0;
		scale_factor_in = '0;
		dac_bs_in = '0;
		dma_valid = 1'b0;
		dma_last = 1'b0;
		dma_data = '0;
		repeat (8) @(negedge ps_clk);
		reset = 1'b0;
		@(negedge ps_clk);
		if (valid_dac_batch !== 1'b0 || dac_intf_rdy !== 1'b1 || pwl_rdy !== 1'b1) begin
			fail_run("Outputs are not at their reset values.");
		end
		check_count("halt_counter", halt_counter, '0);
		write_mailbox(mem_layout_pkg::RUN_PWL_ID, 16'h0001); // Table still empty.
		expect_quiet(8);

		for (int i = 0; i < `DAC_BATCH_SIZE; i++) begin
			raw[i] = 16'(next_random());
			write_mailbox(mem_layout_pkg::id_t'(int'(mem_layout_pkg::SEED_BASE_ID) + i), raw[i]);
		end
		repeat (6) exp_q.push_back(shift_batch(raw, '0));
		write_mailbox(mem_layout_pkg::SEED_VALID_ID, 16'(next_random()) | 16'h0001);
		follow_run();
		halt_run();

		add_ramp(20, '0);
		write_mailbox(mem_layout_pkg::TRIG_WAVE_ID, 16'h0001);
		follow_run();
		halt_run();

		make_segments();
		load_table();
		add_pwl_period('0);
		add_pwl_period('0);
		write_mailbox(mem_layout_pkg::RUN_PWL_ID, 16'h0001);
		follow_run();
		halt_run();

		sh = dac_types_pkg::scale_t'(rand_range(1, 15));
		apply_config(sh, '0);
		add_pwl_period(sh);
		write_mailbox(mem_layout_pkg::RUN_PWL_ID, 16'h0001);
		follow_run();
		halt_run();

		repeat (4) begin
			bs = dac_types_pkg::burst_t'(rand_range(1, `DAC_MAX_BURST));
			apply_config(sh, bs);
			add_ramp(int'(bs), sh);
			write_mailbox(mem_layout_pkg::TRIG_WAVE_ID, 16'h0001);
			count_burst(seen);
			check_count("burst length", dac_types_pkg::burst_t'(seen), bs);
			check_count("halt_counter", halt_counter, bs);
			expect_quiet(6);
		end

		apply_config(sh, '0);
		write_mailbox(mem_layout_pkg::TRIG_WAVE_ID, 16'h0001);
		await_first_batch();
		bs = dac_types_pkg::burst_t'(rand_range(1, `DAC_MAX_BURST));
		dac_bs_in = bs; // Must wait for the halt.
		repeat (12) begin
			if (valid_dac_batch !== 1'b1) fail_run("An endless ramp stopped by itself.");
			check_bs("dac_bs_out", dac_bs_out, '0);
			@(negedge ps_clk);
		end
		halt_run();
		apply_config(sh, bs);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
